// ==== common/rx_intf_cfg.svh ====
// widths and depths of the rx frame path, included by the package and every rx module
`ifndef RX_INTF_CFG_SVH
`define RX_INTF_CFG_SVH

// stream word toward the DMA
`define RX_DATA_W 64
`define RX_BYTES_PER_WORD 8

// 802.11 TSF timer
`define RX_TSF_W 64

// rssi in half dB steps
`define RX_RSSI_W 11

// packet length and received byte count
`define RX_LEN_W 16

// packet sequence number in the trailer
`define RX_SN_W 16

// output FIFO, in stream words
`define RX_FIFO_DEPTH 64

`endif

// ==== common/rx_intf_pkg.sv ====
// packed types shared by the rx frame RTL and its testbench
`include "rx_intf_cfg.svh"

package rx_intf_pkg;

    // header word that follows the timestamp
    typedef struct packed {
        logic [`RX_DATA_W-`RX_LEN_W-8-`RX_RSSI_W-1:0] pad;
        logic [`RX_LEN_W-1:0]                         pkt_len;
        logic [7:0]                                   rate;
        logic [`RX_RSSI_W-1:0]                        rssi;
    } rx_info_t;

    // decoded packet event, one cycle per strobe
    typedef struct packed {
        logic       sop;
        logic       byte_vld;
        logic [7:0] byte_val;
        logic       eop;
        logic       fcs_ok;
    } rx_evt_t;

    typedef struct packed {
        logic                  valid;
        logic [`RX_DATA_W-1:0] data;
    } rx_word_t;

    // last word of every frame
    typedef struct packed {
        logic [`RX_LEN_W-1:0]                          byte_count;
        logic [`RX_SN_W-1:0]                           sn;
        logic [`RX_DATA_W-`RX_LEN_W-`RX_SN_W-2:0]      pad;
        logic                                          fcs_ok;
    } rx_trailer_t;

    typedef struct packed {
        logic                  last;
        logic [`RX_DATA_W-1:0] data;
    } rx_beat_t;

endpackage

// ==== m_axis/sync_fifo.sv ====
// single clock first-word-fall-through FIFO, payload type set by parameter
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH = 16,
    parameter type T     = logic [7:0]
) (
    input  logic clk,
    input  logic arst_n,
    input  logic wr_en,
    input  T     wr_data,
    input  logic rd_en,
    output T     rd_data,
    output logic empty,
    output logic full
);

    localparam int AW = $clog2(DEPTH);

    T             mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // head word is visible without a read request
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    a_no_rd_empty: assert property (
        @(posedge clk) disable iff (!arst_n) rd_en |-> !empty
    );

endmodule

// ==== m_axis/rx_frame_out.sv ====
// builds each frame (tsf, info, data, trailer) into the output FIFO and drives the stream
`include "rx_intf_cfg.svh"

`timescale 1ns/1ps

module rx_frame_out
    import rx_intf_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sop,
    input  rx_info_t              info,
    input  logic [`RX_TSF_W-1:0]  tsf,
    input  logic [`RX_SN_W-1:0]   sn,
    input  logic                  fcs_ok,
    input  rx_word_t              word,
    input  logic [`RX_LEN_W-1:0]  byte_count,
    input  logic                  done,
    input  logic                  m00_axis_tready,
    output logic                  m00_axis_tvalid,
    output logic [`RX_DATA_W-1:0] m00_axis_tdata,
    output logic                  m00_axis_tlast,
    output logic                  rx_pkt_intr
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_INFO,
        S_BODY
    } seq_t;

    seq_t        state;
    rx_trailer_t trailer;
    rx_beat_t    wr_beat;
    rx_beat_t    head;
    logic        fifo_wr;
    logic        fifo_rd;
    logic        fifo_empty;
    logic        fifo_full;

    assign trailer.byte_count = byte_count;
    assign trailer.sn         = sn;
    assign trailer.pad        = '0;
    assign trailer.fcs_ok     = fcs_ok;

    // select which word of the frame goes in this cycle
    always_comb
    begin
        fifo_wr = 1'b0;
        wr_beat = '0;
        case (state)
            S_IDLE:
            begin
                fifo_wr      = sop;
                wr_beat.data = tsf;
            end
            S_INFO:
            begin
                fifo_wr      = 1'b1;
                wr_beat.data = info;
            end
            S_BODY:
            begin
                if (word.valid)
                begin
                    fifo_wr      = 1'b1;
                    wr_beat.data = word.data;
                end
                else if (done)
                begin
                    fifo_wr      = 1'b1;
                    wr_beat.data = trailer;
                    wr_beat.last = 1'b1;
                end
            end
            default:
            begin
                fifo_wr = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= S_IDLE;
            rx_pkt_intr <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:  if (sop) state <= S_INFO;
                S_INFO:  state <= S_BODY;
                S_BODY:  if (done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            // frame fully handed over once its trailer leaves
            rx_pkt_intr <= fifo_rd & head.last;
        end
    end

    sync_fifo #(
        .DEPTH (`RX_FIFO_DEPTH),
        .T     (rx_beat_t)
    ) sync_fifo_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (fifo_wr),
        .wr_data (wr_beat),
        .rd_en   (fifo_rd),
        .rd_data (head),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    assign m00_axis_tvalid = ~fifo_empty;
    assign m00_axis_tdata  = head.data;
    assign m00_axis_tlast  = head.last;
    assign fifo_rd         = m00_axis_tvalid & m00_axis_tready;

    // depends on the source draining each frame before the next one starts
    a_no_wr_full: assert property (
        @(posedge clk) disable iff (!arst_n) fifo_wr |-> !fifo_full
    );

endmodule

// ==== verilog/byte_to_word_pack.sv ====
// packs packet bytes little-endian into stream words and flushes the tail at packet end
`include "rx_intf_cfg.svh"

`timescale 1ns/1ps

module byte_to_word_pack
    import rx_intf_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  rx_evt_t              evt,
    output rx_word_t             word,
    output logic [`RX_LEN_W-1:0] byte_count,
    output logic                 done
);

    localparam int LANE_W = $clog2(`RX_BYTES_PER_WORD);
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`RX_BYTES_PER_WORD - 1);

    logic [LANE_W-1:0]     lane;
    logic [`RX_DATA_W-1:0] acc;
    logic [`RX_DATA_W-1:0] merged;
    logic                  word_full;
    logic                  flush;

    // current byte dropped into its lane on top of the bytes so far
    always_comb
    begin
        merged = acc;
        if (evt.byte_vld)
            merged[lane*8 +: 8] = evt.byte_val;
    end

    assign word_full = evt.byte_vld && (lane == LAST_LANE);
    // tail word only if some lanes were filled
    assign flush     = evt.eop && (lane != '0);

    assign word.valid = word_full | flush;
    assign word.data  = merged;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lane       <= '0;
            byte_count <= '0;
            done       <= 1'b0;
        end
        else
        begin
            done <= evt.eop;
            if (evt.sop)
            begin
                lane       <= '0;
                byte_count <= '0;
            end
            else if (evt.byte_vld)
            begin
                lane       <= (lane == LAST_LANE) ? '0 : lane + 1'b1;
                byte_count <= byte_count + 1'b1;
            end
            else if (evt.eop)
            begin
                lane <= '0;
            end
        end
    end

    // accumulator starts empty so unused lanes of the tail stay zero
    always_ff @(posedge clk)
    begin
        if (evt.sop || word_full || evt.eop)
            acc <= '0;
        else if (evt.byte_vld)
            acc <= merged;
    end

endmodule

// ==== verilog/rx_pkt_decode.sv ====
// gates the receiver strobes into packet events and latches the per-packet info
`include "rx_intf_cfg.svh"

`timescale 1ns/1ps

module rx_pkt_decode
    import rx_intf_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pkt_header_valid,
    input  logic                  pkt_header_valid_strobe,
    input  logic [7:0]            pkt_rate,
    input  logic [`RX_LEN_W-1:0]  pkt_len,
    input  logic                  byte_in_strobe,
    input  logic [7:0]            byte_in,
    input  logic                  fcs_in_strobe,
    input  logic                  fcs_ok,
    input  logic [`RX_TSF_W-1:0]  tsf_runtime_val,
    input  logic [`RX_RSSI_W-1:0] rssi_half_db,
    output rx_evt_t               evt,
    output rx_info_t              info,
    output logic [`RX_TSF_W-1:0]  tsf,
    output logic [`RX_SN_W-1:0]   sn,
    output logic                  fcs_ok_led
);

    logic hdr_good;
    logic hdr_bad;
    logic in_pkt;
    logic eop_d;

    assign hdr_good = pkt_header_valid_strobe & pkt_header_valid;
    assign hdr_bad  = pkt_header_valid_strobe & ~pkt_header_valid;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            in_pkt     <= 1'b0;
            evt        <= '0;
            eop_d      <= 1'b0;
            sn         <= '0;
            fcs_ok_led <= 1'b0;
        end
        else
        begin
            // a bad signal field drops whatever was open
            if (hdr_good)
                in_pkt <= 1'b1;
            else if (hdr_bad || fcs_in_strobe)
                in_pkt <= 1'b0;

            evt.sop      <= hdr_good;
            evt.byte_vld <= byte_in_strobe & in_pkt;
            evt.byte_val <= byte_in;
            evt.eop      <= fcs_in_strobe & in_pkt;
            // held until the next packet end, the trailer reads it after eop
            if (fcs_in_strobe && in_pkt)
                evt.fcs_ok <= fcs_ok;

            if (evt.eop && evt.fcs_ok)
                fcs_ok_led <= ~fcs_ok_led;

            // bump one cycle late so the trailer still sees the old number
            eop_d <= evt.eop;
            if (eop_d)
                sn <= sn + 1'b1;
        end
    end

    // info and timestamp of the packet being received
    always_ff @(posedge clk)
    begin
        if (hdr_good)
        begin
            info.pad     <= '0;
            info.pkt_len <= pkt_len;
            info.rate    <= pkt_rate;
            info.rssi    <= rssi_half_db;
            tsf          <= tsf_runtime_val;
        end
    end

    a_no_sop_in_pkt: assert property (
        @(posedge clk) disable iff (!arst_n) evt.sop |-> !$past(in_pkt)
    );

endmodule

// ==== verilog/rx_intf.sv ====
// rx interface top, turns decoded 802.11 packet events and bytes into DMA stream frames
`include "rx_intf_cfg.svh"

`timescale 1ns/1ps

module rx_intf
    import rx_intf_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pkt_header_valid,
    input  logic                  pkt_header_valid_strobe,
    input  logic [7:0]            pkt_rate,
    input  logic [`RX_LEN_W-1:0]  pkt_len,
    input  logic                  byte_in_strobe,
    input  logic [7:0]            byte_in,
    input  logic                  fcs_in_strobe,
    input  logic                  fcs_ok,
    input  logic [`RX_TSF_W-1:0]  tsf_runtime_val,
    input  logic [`RX_RSSI_W-1:0] rssi_half_db,
    input  logic                  m00_axis_tready,
    output logic                  m00_axis_tvalid,
    output logic [`RX_DATA_W-1:0] m00_axis_tdata,
    output logic                  m00_axis_tlast,
    output logic                  rx_pkt_intr,
    output logic                  fcs_ok_led
);

    rx_evt_t                evt;
    rx_info_t               info;
    logic [`RX_TSF_W-1:0]   tsf;
    logic [`RX_SN_W-1:0]    sn;
    rx_word_t               word;
    logic [`RX_LEN_W-1:0]   byte_count;
    logic                   done;

    rx_pkt_decode rx_pkt_decode_i (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .pkt_header_valid        (pkt_header_valid),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .pkt_rate                (pkt_rate),
        .pkt_len                 (pkt_len),
        .byte_in_strobe          (byte_in_strobe),
        .byte_in                 (byte_in),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .tsf_runtime_val         (tsf_runtime_val),
        .rssi_half_db            (rssi_half_db),
        .evt                     (evt),
        .info                    (info),
        .tsf                     (tsf),
        .sn                      (sn),
        .fcs_ok_led              (fcs_ok_led)
    );

    byte_to_word_pack byte_to_word_pack_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .evt        (evt),
        .word       (word),
        .byte_count (byte_count),
        .done       (done)
    );

    rx_frame_out rx_frame_out_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .sop             (evt.sop),
        .info            (info),
        .tsf             (tsf),
        .sn              (sn),
        .fcs_ok          (evt.fcs_ok),
        .word            (word),
        .byte_count      (byte_count),
        .done            (done),
        .m00_axis_tready (m00_axis_tready),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tlast  (m00_axis_tlast),
        .rx_pkt_intr     (rx_pkt_intr)
    );

endmodule

// ==== verification/rx_intf_checker.sv ====
// testbench monitor that models the expected rx_intf frames from the input strobes and compares
`include "rx_intf_cfg.svh"

`timescale 1ns/1ps

module rx_intf_checker
    import rx_intf_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pkt_header_valid,
    input  logic                  pkt_header_valid_strobe,
    input  logic [7:0]            pkt_rate,
    input  logic [`RX_LEN_W-1:0]  pkt_len,
    input  logic                  byte_in_strobe,
    input  logic [7:0]            byte_in,
    input  logic                  fcs_in_strobe,
    input  logic                  fcs_ok,
    input  logic [`RX_TSF_W-1:0]  tsf_runtime_val,
    input  logic [`RX_RSSI_W-1:0] rssi_half_db,
    input  logic                  m00_axis_tready,
    input  logic                  m00_axis_tvalid,
    input  logic [`RX_DATA_W-1:0] m00_axis_tdata,
    input  logic                  m00_axis_tlast,
    input  logic                  rx_pkt_intr,
    input  logic                  fcs_ok_led,
    output int                    errors,
    output int                    checks,
    output int                    pending
);

    rx_beat_t              exp_q[$];
    rx_beat_t              want;
    rx_beat_t              held;
    rx_info_t              info;
    rx_trailer_t           trailer;
    logic [`RX_DATA_W-1:0] cur_word;
    logic                  open_pkt;
    logic                  stalled;
    logic                  intr_exp;
    logic                  last_taken;
    logic                  led_prev;
    logic                  first_cycle;
    int                    lane;
    int                    n_bytes;
    int                    sn_model;
    int                    good_fcs;
    int                    led_toggles;

    function automatic rx_beat_t make_beat(input logic last, input logic [`RX_DATA_W-1:0] data);
        rx_beat_t b;
        b.last = last;
        b.data = data;
        return b;
    endfunction

    always @(posedge clk)
    begin
        if (!arst_n)
        begin
            exp_q.delete();
            cur_word    = '0;
            open_pkt    = 1'b0;
            stalled     = 1'b0;
            intr_exp    = 1'b0;
            last_taken  = 1'b0;
            led_prev    = 1'b0;
            first_cycle = 1'b1;
            lane        = 0;
            n_bytes     = 0;
            sn_model    = 0;
            good_fcs    = 0;
            led_toggles = 0;
            errors      = 0;
            checks      = 0;
        end
        else
        begin
            // outputs must come out of reset idle
            if (first_cycle)
            begin
                checks++;
                if (m00_axis_tvalid || rx_pkt_intr || fcs_ok_led)
                begin
                    errors++;
                    $display("FAIL %0t: outputs not idle after reset", $time);
                end
            end
            first_cycle = 1'b0;

            // a stalled beat must stay put
            if (stalled)
            begin
                checks++;
                if (!m00_axis_tvalid || m00_axis_tdata !== held.data ||
                    m00_axis_tlast !== held.last)
                begin
                    errors++;
                    $display("FAIL %0t: stalled beat %h changed before it was taken",
                             $time, held.data);
                end
            end
            stalled = m00_axis_tvalid && !m00_axis_tready;
            held    = make_beat(m00_axis_tlast, m00_axis_tdata);

            last_taken = 1'b0;
            if (m00_axis_tvalid && m00_axis_tready)
            begin
                checks++;
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("FAIL %0t: beat %h with no frame expected", $time, m00_axis_tdata);
                end
                else
                begin
                    want       = exp_q.pop_front();
                    last_taken = want.last;
                    if (m00_axis_tdata !== want.data || m00_axis_tlast !== want.last)
                    begin
                        errors++;
                        $display("FAIL %0t: beat %h last %b, expected %h last %b", $time,
                                 m00_axis_tdata, m00_axis_tlast, want.data, want.last);
                    end
                end
            end

            if (fcs_ok_led !== led_prev)
                led_toggles++;
            led_prev = fcs_ok_led;

            checks++;
            if (rx_pkt_intr !== intr_exp)
            begin
                errors++;
                $display("FAIL %0t: rx_pkt_intr is %b, expected %b", $time,
                         rx_pkt_intr, intr_exp);
            end
            // led has settled long before the trailer leaves
            if (rx_pkt_intr)
            begin
                checks++;
                if (led_toggles != good_fcs)
                begin
                    errors++;
                    $display("FAIL %0t: fcs_ok_led toggled %0d times for %0d good FCS", $time,
                             led_toggles, good_fcs);
                end
            end
            // expected frame end taken this cycle
            intr_exp = last_taken;

            // reference model gated by the packet state before this strobe
            if (byte_in_strobe && open_pkt)
            begin
                cur_word[lane*8 +: 8] = byte_in;
                lane++;
                n_bytes++;
                if (lane == `RX_BYTES_PER_WORD)
                begin
                    exp_q.push_back(make_beat(1'b0, cur_word));
                    cur_word = '0;
                    lane     = 0;
                end
            end
            if (fcs_in_strobe && open_pkt)
            begin
                if (lane != 0)
                    exp_q.push_back(make_beat(1'b0, cur_word));
                trailer            = '0;
                trailer.byte_count = `RX_LEN_W'(n_bytes);
                trailer.sn         = `RX_SN_W'(sn_model);
                trailer.fcs_ok     = fcs_ok;
                exp_q.push_back(make_beat(1'b1, trailer));
                sn_model++;
                if (fcs_ok)
                    good_fcs++;
            end
            if (pkt_header_valid_strobe && pkt_header_valid)
            begin
                open_pkt     = 1'b1;
                info         = '0;
                info.rssi    = rssi_half_db;
                info.rate    = pkt_rate;
                info.pkt_len = pkt_len;
                exp_q.push_back(make_beat(1'b0, tsf_runtime_val));
                exp_q.push_back(make_beat(1'b0, info));
                cur_word = '0;
                lane     = 0;
                n_bytes  = 0;
            end
            else if (pkt_header_valid_strobe || fcs_in_strobe)
            begin
                open_pkt = 1'b0;
            end
        end
        pending = exp_q.size();
    end

endmodule

// ==== verification/tb_rx_intf.sv ====
// testbench top for rx_intf, drives random packets and reports the result of the checker
`include "rx_intf_cfg.svh"

`timescale 1ns/1ps

module tb_rx_intf;

    localparam int NUM_PKTS    = 80;
    localparam int DRAIN_LIMIT = 2000;

    logic                  clk;
    logic                  arst_n;
    logic                  pkt_header_valid;
    logic                  pkt_header_valid_strobe;
    logic [7:0]            pkt_rate;
    logic [`RX_LEN_W-1:0]  pkt_len;
    logic                  byte_in_strobe;
    logic [7:0]            byte_in;
    logic                  fcs_in_strobe;
    logic                  fcs_ok;
    logic [`RX_TSF_W-1:0]  tsf_runtime_val;
    logic [`RX_RSSI_W-1:0] rssi_half_db;
    logic                  m00_axis_tready;
    logic                  m00_axis_tvalid;
    logic [`RX_DATA_W-1:0] m00_axis_tdata;
    logic                  m00_axis_tlast;
    logic                  rx_pkt_intr;
    logic                  fcs_ok_led;
    int                    chk_errors;
    int                    chk_checks;
    int                    chk_pending;
    int                    tb_errors;
    int                    pkt_idx;
    logic                  timed_out;

    rx_intf uut (.*);

    rx_intf_checker chk (
        .*,
        .errors  (chk_errors),
        .checks  (chk_checks),
        .pending (chk_pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure and a free running timestamp
    initial
    begin
        m00_axis_tready = 1'b0;
        tsf_runtime_val = 64'h0000_0100_0000_0000;
        forever
        begin
            @(negedge clk);
            m00_axis_tready = ($urandom % 4) != 0;
            tsf_runtime_val = tsf_runtime_val + 64'd1;
        end
    end

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic send_header(input logic good, input int n_bytes);
        @(negedge clk);
        pkt_header_valid_strobe = 1'b1;
        pkt_header_valid        = good;
        pkt_rate                = 8'($urandom);
        pkt_len                 = `RX_LEN_W'(n_bytes);
        rssi_half_db            = `RX_RSSI_W'($urandom);
        @(negedge clk);
        pkt_header_valid_strobe = 1'b0;
        pkt_header_valid        = 1'b0;
    endtask

    // bytes back to back or up to two idle cycles apart
    task automatic send_bytes(input int n_bytes);
        int gap;
        for (int i = 0; i < n_bytes; i++)
        begin
            @(negedge clk);
            byte_in_strobe = 1'b1;
            byte_in        = 8'($urandom);
            gap            = int'($urandom % 3);
            if (gap != 0)
            begin
                @(negedge clk);
                byte_in_strobe = 1'b0;
                idle(gap - 1);
            end
        end
        @(negedge clk);
        byte_in_strobe = 1'b0;
    endtask

    task automatic send_fcs(input logic ok);
        @(negedge clk);
        fcs_in_strobe = 1'b1;
        fcs_ok        = ok;
        @(negedge clk);
        fcs_in_strobe = 1'b0;
    endtask

    task automatic wait_frame_drained(output logic drained);
        int cycles;
        cycles  = 0;
        drained = 1'b0;
        while (!drained && cycles < DRAIN_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            if (rx_pkt_intr)
                drained = 1'b1;
        end
    endtask

    task automatic run_packet(input int idx, output logic stuck);
        logic good;
        logic drained;
        int   n_bytes;
        good    = ($urandom % 5) != 0;
        n_bytes = 1 + int'($urandom % 200);
        stuck   = 1'b0;
        send_header(good, n_bytes);
        idle(3 + int'($urandom % 4));
        send_bytes(n_bytes);
        idle(3 + int'($urandom % 4));
        send_fcs(($urandom % 2) != 0);
        if (good)
        begin
            wait_frame_drained(drained);
            if (!drained)
            begin
                $display("timeout: frame of packet %0d not drained within %0d cycles",
                         idx, DRAIN_LIMIT);
                stuck = 1'b1;
            end
        end
        // strays with no packet open
        if (($urandom % 4) == 0)
        begin
            send_bytes(1 + int'($urandom % 5));
            idle(2);
            send_fcs(1'b1);
        end
        idle(2 + int'($urandom % 5));
    endtask

    initial
    begin
        void'($urandom(32'hf154));
        arst_n                  = 1'b0;
        pkt_header_valid        = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        pkt_rate                = '0;
        pkt_len                 = '0;
        byte_in_strobe          = 1'b0;
        byte_in                 = '0;
        fcs_in_strobe           = 1'b0;
        fcs_ok                  = 1'b0;
        rssi_half_db            = '0;
        tb_errors               = 0;
        timed_out               = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        idle(3);

        for (pkt_idx = 0; pkt_idx < NUM_PKTS && !timed_out; pkt_idx++)
            run_packet(pkt_idx, timed_out);

        if (timed_out)
        begin
            tb_errors++;
        end
        else if (chk_pending != 0)
        begin
            $display("%0d expected beats never left the DUT", chk_pending);
            tb_errors++;
        end

        $display("checks: %0d, errors: %0d", chk_checks, chk_errors + tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+common
common/rx_intf_pkg.sv
m_axis/sync_fifo.sv
m_axis/rx_frame_out.sv
verilog/byte_to_word_pack.sv
verilog/rx_pkt_decode.sv
verilog/rx_intf.sv
verification/rx_intf_checker.sv
verification/tb_rx_intf.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rx_intf testbench with Verilator, run it, pass only on the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_rx_intf \
        -f files.f -o sim_rx_intf; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/sim_rx_intf); then
    echo "$out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
